/* source/spm_defines.svh */
`ifndef SPM_DEFINES_SVH
`define SPM_DEFINES_SVH

// lanes and banks are paired one to one, and the bank select is two bits wide.
`define SPM_LANES 4

// row address width inside one bank, 256 words by default.
`define SPM_ROW_W 8

// width of one data word.
`define SPM_DATA_W 32

`endif

/* source/spm_pkg.sv */
`include "spm_defines.svh"

package spm_pkg;

    typedef logic [1:0]             bank_sel_t;
    typedef logic [`SPM_ROW_W-1:0]  row_addr_t;
    typedef logic [`SPM_DATA_W-1:0] data_t;
    typedef logic [1:0]             lane_id_t;   // response tag.

    // one request as presented by a load/store lane.
    typedef struct packed {
        logic      valid;
        logic      write;
        bank_sel_t bank;
        row_addr_t row;
        data_t     wdata;
    } lane_req_t;

    // a granted request on its way into a bank, tagged with the issuing lane.
    typedef struct packed {
        logic      valid;
        logic      write;
        lane_id_t  lane;
        row_addr_t row;
        data_t     wdata;
    } bank_req_t;

    typedef struct packed {
        logic     valid;
        lane_id_t lane;
        data_t    rdata;
    } lane_rsp_t;

endpackage

/* source/lane_req_xbar.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module lane_req_xbar (
    input  spm_pkg::lane_req_t    lane_req [`SPM_LANES],
    output spm_pkg::bank_req_t    bank_req [`SPM_LANES],
    output logic [`SPM_LANES-1:0] lane_conflict
);

    // match[b][l] is set when lane l has a valid request for bank b.
    logic [`SPM_LANES-1:0] match [`SPM_LANES];
    logic [`SPM_LANES-1:0] grant [`SPM_LANES];
    logic [`SPM_LANES-1:0] lane_hit;

    always_comb begin
        for (int b = 0; b < `SPM_LANES; b++) begin
            for (int l = 0; l < `SPM_LANES; l++) begin
                match[b][l] = lane_req[l].valid &&
                              (lane_req[l].bank == spm_pkg::bank_sel_t'(b));
            end
        end
    end

    genvar gb;
    generate
        for (gb = 0; gb < `SPM_LANES; gb++) begin : g_bank
            spm_pkg::lane_id_t sel;

            // isolate the lowest set bit, so lane 0 beats lane 1 and so on.
            assign grant[gb] = match[gb] & (~match[gb] + 1'b1);

            always_comb begin
                sel = '0;
                for (int l = 0; l < `SPM_LANES; l++) begin
                    if (grant[gb][l]) begin
                        sel = spm_pkg::lane_id_t'(l);
                    end
                end
            end

            always_comb begin
                bank_req[gb] = '0;                   // idle bank sees all zeros.
                if (|grant[gb]) begin
                    bank_req[gb].valid = 1'b1;
                    bank_req[gb].write = lane_req[sel].write;
                    bank_req[gb].lane  = sel;
                    bank_req[gb].row   = lane_req[sel].row;
                    bank_req[gb].wdata = lane_req[sel].wdata;
                end
            end
        end
    endgenerate

    // a lane is served when any bank granted it.
    always_comb begin
        lane_hit = '0;
        for (int b = 0; b < `SPM_LANES; b++) begin
            lane_hit = lane_hit | grant[b];
        end
    end

    // a valid request that no bank granted lost to a lower lane.
    always_comb begin
        for (int l = 0; l < `SPM_LANES; l++) begin
            lane_conflict[l] = lane_req[l].valid && !lane_hit[l];
        end
    end

endmodule

/* source/bank_sram.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module bank_sram (
    input  logic               clk,
    input  logic               rst,
    input  spm_pkg::bank_req_t req,
    output spm_pkg::lane_rsp_t rsp
);

    localparam int DEPTH = 1 << `SPM_ROW_W;

    spm_pkg::data_t    mem [DEPTH];
    spm_pkg::data_t    rdata_q;
    spm_pkg::lane_id_t lane_q;
    logic              valid_q;
    logic              rd_en;
    logic              wr_en;

    assign wr_en = req.valid && req.write;
    assign rd_en = req.valid && !req.write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[req.row] <= req.wdata;
        end
    end

    // the read samples the array before any write at the same edge lands.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= mem[req.row];
            lane_q  <= req.lane;   // tag travels with the data.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_en;      // one cycle pulse per granted read.
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.lane  = lane_q;
    assign rsp.rdata = rdata_q;

endmodule

/* source/lane_rsp_xbar.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module lane_rsp_xbar (
    input  spm_pkg::lane_rsp_t bank_rsp [`SPM_LANES],
    output spm_pkg::lane_rsp_t lane_rsp [`SPM_LANES]
);

    // hit[l][b] is set when bank b holds a response tagged for lane l.
    logic [`SPM_LANES-1:0] hit [`SPM_LANES];

    always_comb begin
        for (int l = 0; l < `SPM_LANES; l++) begin
            for (int b = 0; b < `SPM_LANES; b++) begin
                hit[l][b] = bank_rsp[b].valid &&
                            (bank_rsp[b].lane == spm_pkg::lane_id_t'(l));
            end
        end
    end

    genvar gl;
    generate
        for (gl = 0; gl < `SPM_LANES; gl++) begin : g_lane
            spm_pkg::data_t rdata;

            // at most one bank can answer a lane, so an OR of the masked data is enough.
            always_comb begin
                rdata = '0;
                for (int b = 0; b < `SPM_LANES; b++) begin
                    if (hit[gl][b]) begin
                        rdata = rdata | bank_rsp[b].rdata;
                    end
                end
            end

            assign lane_rsp[gl].valid = |hit[gl];
            assign lane_rsp[gl].lane  = '0;   // the port already names the lane.
            assign lane_rsp[gl].rdata = rdata;
        end
    endgenerate

endmodule

/* source/spm_top.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module spm_top (
    input  logic                  clk,
    input  logic                  rst,
    input  spm_pkg::lane_req_t    lane_req [`SPM_LANES],
    output spm_pkg::lane_rsp_t    lane_rsp [`SPM_LANES],
    output logic [`SPM_LANES-1:0] lane_conflict
);

    spm_pkg::bank_req_t bank_req [`SPM_LANES];
    spm_pkg::lane_rsp_t bank_rsp [`SPM_LANES];

    // requests fan out to banks with fixed lane priority.
    lane_req_xbar u_req_xbar (
        .lane_req      (lane_req),
        .bank_req      (bank_req),
        .lane_conflict (lane_conflict)
    );

    genvar gb;
    generate
        for (gb = 0; gb < `SPM_LANES; gb++) begin : g_bank
            bank_sram u_bank (
                .clk (clk),
                .rst (rst),
                .req (bank_req[gb]),
                .rsp (bank_rsp[gb])
            );
        end
    endgenerate

    // read data finds its way home by the lane tag.
    lane_rsp_xbar u_rsp_xbar (
        .bank_rsp (bank_rsp),
        .lane_rsp (lane_rsp)
    );

endmodule

/* test/spm_sva.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module spm_sva (
    input logic                  clk,
    input logic                  rst,
    input spm_pkg::lane_req_t    lane_req [`SPM_LANES],
    input spm_pkg::lane_rsp_t    lane_rsp [`SPM_LANES],
    input logic [`SPM_LANES-1:0] lane_conflict
);

    logic [`SPM_LANES-1:0] rsp_valid;
    logic [`SPM_LANES-1:0] rd_granted;   // valid read that lost no arbitration.
    logic                  bank_clash;

    always_comb begin
        bank_clash = 1'b0;
        for (int l = 0; l < `SPM_LANES; l++) begin
            rsp_valid[l]  = lane_rsp[l].valid;
            rd_granted[l] = lane_req[l].valid && !lane_req[l].write && !lane_conflict[l];
        end
        for (int i = 0; i < `SPM_LANES; i++) begin
            for (int j = i + 1; j < `SPM_LANES; j++) begin
                if (lane_req[i].valid && lane_req[j].valid &&
                    !lane_conflict[i] && !lane_conflict[j] &&
                    (lane_req[i].bank == lane_req[j].bank)) begin
                    bank_clash = 1'b1;
                end
            end
        end
    end

    genvar gl;
    generate
        for (gl = 0; gl < `SPM_LANES; gl++) begin : g_lane
            a_rsp_after_read: assert property (@(posedge clk) disable iff (rst)
                rsp_valid[gl] |-> $past(rd_granted[gl]))
                else $error("lane %0d got a response without a granted read", gl);
        end
    endgenerate

    a_one_lane_per_bank: assert property (@(posedge clk) disable iff (rst) !bank_clash)
        else $error("two granted lanes target the same bank");

    a_quiet_after_reset: assert property (@(posedge clk) rst |=> (rsp_valid == '0))
        else $error("a response is valid right after reset");

endmodule

/* test/spm_tb.sv */
`timescale 1ns/1ps
`include "spm_defines.svh"

module spm_tb;

    localparam int ROWS         = 1 << `SPM_ROW_W;
    localparam int IDLE_TIMEOUT = 8;

    logic                  clk;
    logic                  rst;
    spm_pkg::lane_req_t    lane_req [`SPM_LANES];
    spm_pkg::lane_rsp_t    lane_rsp [`SPM_LANES];
    logic [`SPM_LANES-1:0] lane_conflict;

    spm_pkg::data_t        ref_mem [`SPM_LANES][ROWS];   // reference copy of all banks.
    spm_pkg::lane_req_t    req_vec [`SPM_LANES];         // requests for the next cycle.
    logic [`SPM_LANES-1:0] exp_valid;
    spm_pkg::data_t        exp_data [`SPM_LANES];
    logic [31:0]           rng;

    spm_top uut (
        .clk           (clk),
        .rst           (rst),
        .lane_req      (lane_req),
        .lane_rsp      (lane_rsp),
        .lane_conflict (lane_conflict)
    );

    bind spm_top spm_sva u_sva (
        .clk           (clk),
        .rst           (rst),
        .lane_req      (lane_req),
        .lane_rsp      (lane_rsp),
        .lane_conflict (lane_conflict)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic spm_pkg::data_t fill_word(input int b, input int r);
        return spm_pkg::data_t'(32'h5a00_0000 ^ (b << 20) ^ (r << 8) ^ r);
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic fail_msg(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    task automatic clear_reqs;
        for (int l = 0; l < `SPM_LANES; l++) begin
            req_vec[l] = '0;
        end
    endtask

    task automatic set_req(input int l, input logic write, input int bank, input int row,
                           input spm_pkg::data_t wdata);
        req_vec[l].valid = 1'b1;
        req_vec[l].write = write;
        req_vec[l].bank  = spm_pkg::bank_sel_t'(bank);
        req_vec[l].row   = spm_pkg::row_addr_t'(row);
        req_vec[l].wdata = wdata;
    endtask

    // one clock cycle: drive req_vec, predict from the model, check at the falling edge.
    task automatic drive_cycle;
        logic [`SPM_LANES-1:0] taken;
        logic [`SPM_LANES-1:0] exp_conf;
        logic [`SPM_LANES-1:0] nxt_valid;
        spm_pkg::data_t        nxt_data [`SPM_LANES];
        spm_pkg::lane_req_t    q;
        @(posedge clk);
        for (int l = 0; l < `SPM_LANES; l++) begin
            lane_req[l] <= req_vec[l];
        end
        taken     = '0;
        exp_conf  = '0;
        nxt_valid = '0;
        for (int l = 0; l < `SPM_LANES; l++) begin
            q           = req_vec[l];
            nxt_data[l] = '0;
            if (q.valid) begin
                if (taken[q.bank]) begin
                    exp_conf[l] = 1'b1;   // a lower lane already holds this bank.
                end else begin
                    taken[q.bank] = 1'b1;
                    if (q.write) begin
                        ref_mem[q.bank][q.row] = q.wdata;
                    end else begin
                        nxt_valid[l] = 1'b1;
                        nxt_data[l]  = ref_mem[q.bank][q.row];
                    end
                end
            end
        end
        @(negedge clk);
        for (int l = 0; l < `SPM_LANES; l++) begin
            assert (lane_rsp[l].valid === exp_valid[l])
                else fail_value($sformatf("lane_rsp[%0d].valid", l),
                                32'(lane_rsp[l].valid), 32'(exp_valid[l]));
            if (exp_valid[l]) begin
                assert (lane_rsp[l].rdata === exp_data[l])
                    else fail_value($sformatf("lane_rsp[%0d].rdata", l),
                                    lane_rsp[l].rdata, exp_data[l]);
            end
            assert (lane_rsp[l].lane === '0)   // the tag is cleared on the way out.
                else fail_value($sformatf("lane_rsp[%0d].lane", l),
                                32'(lane_rsp[l].lane), 32'h0);
        end
        assert (lane_conflict === exp_conf)
            else fail_value("lane_conflict", 32'(lane_conflict), 32'(exp_conf));
        exp_valid = nxt_valid;
        for (int l = 0; l < `SPM_LANES; l++) begin
            exp_data[l] = nxt_data[l];
        end
    endtask

    function automatic logic any_rsp_valid();
        logic v;
        v = 1'b0;
        for (int l = 0; l < `SPM_LANES; l++) begin
            v = v | lane_rsp[l].valid;
        end
        return v;
    endfunction

    task automatic wait_idle;
        int n;
        n = 0;
        clear_reqs();
        drive_cycle();
        while (any_rsp_valid()) begin
            if (n == IDLE_TIMEOUT) begin
                fail_msg("read responses kept arriving with no requests pending");
            end else begin
                drive_cycle();
                n++;
            end
        end
    endtask

    task automatic check_rsp(input int l, input spm_pkg::data_t d);
        assert (lane_rsp[l].valid === 1'b1)
            else fail_msg($sformatf("no read response arrived on lane %0d", l));
        assert (lane_rsp[l].rdata === d)
            else fail_value($sformatf("lane_rsp[%0d].rdata", l), lane_rsp[l].rdata, d);
    endtask

    task automatic check_no_rsp(input int l);
        assert (lane_rsp[l].valid === 1'b0)
            else fail_msg($sformatf("lane %0d got a response for a dropped request", l));
    endtask

    task automatic reset_check;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            for (int l = 0; l < `SPM_LANES; l++) begin
                check_no_rsp(l);
            end
            assert (lane_conflict === '0)
                else fail_value("lane_conflict", 32'(lane_conflict), 32'h0);
        end
        clear_reqs();
        drive_cycle();
        drive_cycle();
    endtask

    task automatic single_lane_test;
        for (int b = 0; b < `SPM_LANES; b++) begin
            clear_reqs();
            set_req(0, 1'b1, b, 8'h10 + b, 32'h0a00_0000 + b * 32'h111);
            drive_cycle();
        end
        for (int b = 0; b < `SPM_LANES; b++) begin
            clear_reqs();
            set_req(0, 1'b0, b, 8'h10 + b, '0);
            drive_cycle();
            clear_reqs();
            drive_cycle();
            check_rsp(0, 32'h0a00_0000 + b * 32'h111);
        end
        wait_idle();
    endtask

    // lane l uses bank 3 - l, so all four lanes hit distinct banks.
    task automatic parallel_test;
        clear_reqs();
        for (int l = 0; l < `SPM_LANES; l++) begin
            set_req(l, 1'b1, 3 - l, 8'h40 + l, 32'hcafe_0000 + l);
        end
        drive_cycle();
        clear_reqs();
        for (int l = 0; l < `SPM_LANES; l++) begin
            set_req(l, 1'b0, 3 - l, 8'h40 + l, '0);
        end
        drive_cycle();
        assert (lane_conflict === '0)
            else fail_value("lane_conflict", 32'(lane_conflict), 32'h0);
        clear_reqs();
        drive_cycle();
        for (int l = 0; l < `SPM_LANES; l++) begin
            check_rsp(l, 32'hcafe_0000 + l);
        end
        wait_idle();
    endtask

    task automatic conflict_test;
        clear_reqs();
        set_req(0, 1'b1, 2, 8'h80, 32'h1111_1111);
        drive_cycle();
        clear_reqs();
        set_req(0, 1'b1, 2, 8'h81, 32'h2222_2222);
        set_req(1, 1'b1, 2, 8'h80, 32'hdead_beef);   // loses to lane 0.
        set_req(2, 1'b0, 2, 8'h80, '0);              // loses as well.
        set_req(3, 1'b0, 1, 8'h42, '0);
        drive_cycle();
        assert (lane_conflict === 4'b0110)
            else fail_value("lane_conflict", 32'(lane_conflict), 32'h6);
        clear_reqs();
        drive_cycle();
        check_no_rsp(2);
        check_rsp(3, 32'hcafe_0002);
        clear_reqs();
        set_req(2, 1'b0, 2, 8'h80, '0);
        set_req(3, 1'b0, 2, 8'h81, '0);
        drive_cycle();
        assert (lane_conflict === 4'b1000)
            else fail_value("lane_conflict", 32'(lane_conflict), 32'h8);
        clear_reqs();
        drive_cycle();
        check_rsp(2, 32'h1111_1111);
        check_no_rsp(3);
        clear_reqs();
        set_req(3, 1'b0, 2, 8'h81, '0);
        drive_cycle();
        clear_reqs();
        drive_cycle();
        check_rsp(3, 32'h2222_2222);
        wait_idle();
    endtask

    task automatic preload;
        for (int r = 0; r < ROWS; r++) begin
            clear_reqs();
            for (int l = 0; l < `SPM_LANES; l++) begin
                set_req(l, 1'b1, l, r, fill_word(l, r));
            end
            drive_cycle();
        end
        wait_idle();
    endtask

    task automatic random_test;
        logic [31:0] r;
        preload();   // every word is known before random reads start.
        for (int c = 0; c < 400; c++) begin
            for (int l = 0; l < `SPM_LANES; l++) begin
                rng = xorshift(rng);
                r   = rng;
                rng = xorshift(rng);
                req_vec[l].valid = r[0] | r[1];
                req_vec[l].write = r[2];
                req_vec[l].bank  = r[4:3];
                req_vec[l].row   = spm_pkg::row_addr_t'(r >> 5);
                req_vec[l].wdata = rng;
            end
            drive_cycle();
        end
        wait_idle();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        rng       = 32'h989;
        exp_valid = '0;
        for (int l = 0; l < `SPM_LANES; l++) begin
            lane_req[l] = '0;
            exp_data[l] = '0;
        end
        clear_reqs();
        reset_check();
        single_lane_test();
        parallel_test();
        conflict_test();
        random_test();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/spm_pkg.sv
source/lane_req_xbar.sv
source/bank_sram.sv
source/lane_rsp_xbar.sv
source/spm_top.sv
test/spm_sva.sv
test/spm_tb.sv

/* Bender.yml */
package:
  name: spm

sources:
  - include_dirs:
      - source
    files:
      - source/spm_pkg.sv
      - source/lane_req_xbar.sv
      - source/bank_sram.sv
      - source/lane_rsp_xbar.sv
      - source/spm_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/spm_sva.sv
      - test/spm_tb.sv
